//--- Bender.yml
package:
  name: microstepper

sources:
  - logic/microstepper_pkg.sv
  - logic/step_input.sv
  - logic/current_table.sv
  - logic/pwm_dac.sv
  - logic/coil_chopper.sv
  - logic/bridge_driver.sv
  - logic/microstepper_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/microstepper_assert.sv
      - tb/microstepper_tb.sv

//--- logic/bridge_driver.sv
module bridge_driver import microstepper_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            enable_in,
    input  logic            drive_on_a,
    input  logic            drive_on_b,
    input  logic            neg_a,
    input  logic            neg_b,
    input  logic            config_invert_highside,
    input  logic            config_invert_lowside,
    input  logic [CP_W-1:0] config_chargepump_period,
    output logic            phase_a1_h,
    output logic            phase_a1_l,
    output logic            phase_a2_h,
    output logic            phase_a2_l,
    output logic            phase_b1_h,
    output logic            phase_b1_l,
    output logic            phase_b2_h,
    output logic            phase_b2_l,
    output logic            chargepump_pin
);

    // gate order in every 4-bit vector: {1_h, 1_l, 2_h, 2_l}
    function automatic logic [3:0] leg_gates(
        input logic enable,
        input logic drive,
        input logic neg
    );
        logic [3:0] g;
        if (!enable) begin
            g = 4'b0000;
        end else if (!drive) begin
            // slow decay through both low sides
            g = 4'b0101;
        end else if (neg) begin
            g = 4'b0110;
        end else begin
            g = 4'b1001;
        end
        return g;
    endfunction

    logic [3:0] raw_a;
    logic [3:0] raw_b;
    logic [3:0] inv_mask;
    logic [3:0] gates_a;
    logic [3:0] gates_b;
    logic [CP_W-1:0] cp_cnt;
    logic            cp_wrap;

    assign raw_a    = leg_gates(enable_in, drive_on_a, neg_a);
    assign raw_b    = leg_gates(enable_in, drive_on_b, neg_b);
    assign inv_mask = {config_invert_highside, config_invert_lowside,
                       config_invert_highside, config_invert_lowside};

    // in reset the bridge sits in the disabled state, polarity options still honored
    always_ff @(posedge clk) begin
        if (!resetn) begin
            gates_a <= inv_mask;
            gates_b <= inv_mask;
        end else begin
            gates_a <= raw_a ^ inv_mask;
            gates_b <= raw_b ^ inv_mask;
        end
    end

    assign {phase_a1_h, phase_a1_l, phase_a2_h, phase_a2_l} = gates_a;
    assign {phase_b1_h, phase_b1_l, phase_b2_h, phase_b2_l} = gates_b;

    // ##############################
    // charge pump
    // ##############################

    // a period of 0 behaves as 1
    assign cp_wrap = ((cp_cnt + CP_W'(1)) >= config_chargepump_period);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cp_cnt         <= '0;
            chargepump_pin <= 1'b0;
        end else if (cp_wrap) begin
            cp_cnt         <= '0;
            chargepump_pin <= ~chargepump_pin;
        end else begin
            cp_cnt <= cp_cnt + CP_W'(1);
        end
    end

endmodule

//--- logic/coil_chopper.sv
module coil_chopper import microstepper_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 enable_in,
    input  logic                 cmp,
    input  logic [OFFTIME_W-1:0] config_offtime,
    input  logic [BLANK_W-1:0]   config_blanktime,
    output logic                 drive_on
);

    // comparator comes straight from the analog side
    logic cmp_s1;
    logic cmp_s2;

    logic                 off_state;
    logic [BLANK_W-1:0]   blank_cnt;
    logic [OFFTIME_W-1:0] off_cnt;
    logic                 blank_done;
    logic                 off_done;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cmp_s1 <= 1'b0;
            cmp_s2 <= 1'b0;
        end else begin
            cmp_s1 <= cmp;
            cmp_s2 <= cmp_s1;
        end
    end

    // >= so that a setting lowered mid-count still ends the phase
    assign blank_done = (blank_cnt >= config_blanktime);
    assign off_done   = ((off_cnt + OFFTIME_W'(1)) >= config_offtime);

    // ##############################
    // on / off-time FSM
    // ##############################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            off_state <= 1'b0;
            blank_cnt <= '0;
            off_cnt   <= '0;
        end else if (!enable_in) begin
            off_state <= 1'b0;
            blank_cnt <= '0;
            off_cnt   <= '0;
        end else if (off_state) begin
            if (off_done) begin
                off_state <= 1'b0;
                blank_cnt <= '0;
            end else begin
                off_cnt <= off_cnt + OFFTIME_W'(1);
            end
        end else if (!blank_done) begin
            // bridge switching noise, comparator not trusted yet
            blank_cnt <= blank_cnt + BLANK_W'(1);
        end else if (cmp_s2) begin
            off_state <= 1'b1;
            off_cnt   <= '0;
        end
    end

    assign drive_on = ~off_state;

endmodule

//--- logic/current_table.sv
module current_table import microstepper_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  phase_t           phase,
    output logic [MAG_W-1:0] mag_a,
    output logic [MAG_W-1:0] mag_b,
    output logic             neg_a,
    output logic             neg_b
);

    logic [INDEX_W-1:0] idx_fwd;
    logic [INDEX_W-1:0] idx_rev;
    logic               fold;

    assign idx_fwd = phase.split.index;
    assign idx_rev = INDEX_W'(TABLE_DEPTH - 1) - phase.split.index;

    // odd quadrants walk the quarter wave backwards for coil A
    assign fold = phase.split.quadrant[0];

    // ##############################
    // magnitudes
    // ##############################

    // coil A is the sine, coil B the cosine, so their folds are swapped
    always_ff @(posedge clk) begin
        mag_a <= SINE_TABLE[fold ? idx_rev : idx_fwd];
        mag_b <= SINE_TABLE[fold ? idx_fwd : idx_rev];
    end

    // ##############################
    // signs
    // ##############################

    // sine is negative in quadrants 2 and 3, cosine in 1 and 2
    always_ff @(posedge clk) begin
        if (!resetn) begin
            neg_a <= 1'b0;
            neg_b <= 1'b0;
        end else begin
            neg_a <= phase.split.quadrant[1];
            neg_b <= phase.split.quadrant[1] ^ phase.split.quadrant[0];
        end
    end

endmodule

//--- logic/microstepper_pkg.sv
package microstepper_pkg;

    // ##############################
    // widths
    // ##############################

    localparam int PHASE_W   = 8;
    localparam int MAG_W     = 8;
    localparam int INDEX_W   = 6;
    localparam int OFFTIME_W = 10;
    localparam int BLANK_W   = 8;
    localparam int CP_W      = 8;

    localparam int TABLE_DEPTH = 1 << INDEX_W;

    // ##############################
    // electrical phase word
    // ##############################

    // raw count for stepping, quadrant and index for the table lookup
    typedef union packed {
        logic [PHASE_W-1:0] raw;
        struct packed {
            logic [PHASE_W-INDEX_W-1:0] quadrant;
            logic [INDEX_W-1:0]         index;
        } split;
    } phase_t;

    // ##############################
    // quarter-wave sine
    // ##############################

    // 255 * sin((i + 0.5) * pi / 128), sampled mid-step so both folds stay symmetric
    localparam logic [MAG_W-1:0] SINE_TABLE [0:TABLE_DEPTH-1] = '{
        8'd3,   8'd9,   8'd16,  8'd22,  8'd28,  8'd34,  8'd41,  8'd47,
        8'd53,  8'd59,  8'd65,  8'd71,  8'd77,  8'd83,  8'd89,  8'd95,
        8'd100, 8'd106, 8'd112, 8'd117, 8'd123, 8'd128, 8'd134, 8'd139,
        8'd144, 8'd149, 8'd154, 8'd159, 8'd164, 8'd169, 8'd174, 8'd178,
        8'd183, 8'd187, 8'd191, 8'd195, 8'd199, 8'd203, 8'd207, 8'd210,
        8'd214, 8'd217, 8'd220, 8'd223, 8'd226, 8'd229, 8'd232, 8'd234,
        8'd237, 8'd239, 8'd241, 8'd243, 8'd245, 8'd247, 8'd248, 8'd249,
        8'd251, 8'd252, 8'd253, 8'd253, 8'd254, 8'd255, 8'd255, 8'd255
    };

endpackage

//--- logic/microstepper_top.sv
module microstepper_top import microstepper_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 step,
    input  logic                 dir,
    input  logic                 enable_in,
    input  logic                 analog_cmp_a,
    input  logic                 analog_cmp_b,
    input  logic [OFFTIME_W-1:0] config_offtime,
    input  logic [BLANK_W-1:0]   config_blanktime,
    input  logic [CP_W-1:0]      config_chargepump_period,
    input  logic                 config_invert_highside,
    input  logic                 config_invert_lowside,
    output logic                 phase_a1_h,
    output logic                 phase_a1_l,
    output logic                 phase_a2_h,
    output logic                 phase_a2_l,
    output logic                 phase_b1_h,
    output logic                 phase_b1_l,
    output logic                 phase_b2_h,
    output logic                 phase_b2_l,
    output logic                 analog_out_a,
    output logic                 analog_out_b,
    output logic                 chargepump_pin,
    output logic [PHASE_W-1:0]   position
);

    phase_t           phase;
    logic [MAG_W-1:0] mag_a;
    logic [MAG_W-1:0] mag_b;
    logic             neg_a;
    logic             neg_b;
    logic             drive_on_a;
    logic             drive_on_b;

    assign position = phase.raw;

    // ##############################
    // phase and current setpoints
    // ##############################

    step_input step_input_i (
        .clk    (clk),
        .resetn (resetn),
        .step   (step),
        .dir    (dir),
        .phase  (phase)
    );

    current_table current_table_i (
        .clk    (clk),
        .resetn (resetn),
        .phase  (phase),
        .mag_a  (mag_a),
        .mag_b  (mag_b),
        .neg_a  (neg_a),
        .neg_b  (neg_b)
    );

    pwm_dac pwm_dac_a (
        .clk    (clk),
        .resetn (resetn),
        .mag    (mag_a),
        .pwm    (analog_out_a)
    );

    pwm_dac pwm_dac_b (
        .clk    (clk),
        .resetn (resetn),
        .mag    (mag_b),
        .pwm    (analog_out_b)
    );

    // ##############################
    // current regulation and bridges
    // ##############################

    coil_chopper coil_chopper_a (
        .clk              (clk),
        .resetn           (resetn),
        .enable_in        (enable_in),
        .cmp              (analog_cmp_a),
        .config_offtime   (config_offtime),
        .config_blanktime (config_blanktime),
        .drive_on         (drive_on_a)
    );

    coil_chopper coil_chopper_b (
        .clk              (clk),
        .resetn           (resetn),
        .enable_in        (enable_in),
        .cmp              (analog_cmp_b),
        .config_offtime   (config_offtime),
        .config_blanktime (config_blanktime),
        .drive_on         (drive_on_b)
    );

    bridge_driver bridge_driver_i (
        .clk                      (clk),
        .resetn                   (resetn),
        .enable_in                (enable_in),
        .drive_on_a               (drive_on_a),
        .drive_on_b               (drive_on_b),
        .neg_a                    (neg_a),
        .neg_b                    (neg_b),
        .config_invert_highside   (config_invert_highside),
        .config_invert_lowside    (config_invert_lowside),
        .config_chargepump_period (config_chargepump_period),
        .phase_a1_h               (phase_a1_h),
        .phase_a1_l               (phase_a1_l),
        .phase_a2_h               (phase_a2_h),
        .phase_a2_l               (phase_a2_l),
        .phase_b1_h               (phase_b1_h),
        .phase_b1_l               (phase_b1_l),
        .phase_b2_h               (phase_b2_h),
        .phase_b2_l               (phase_b2_l),
        .chargepump_pin           (chargepump_pin)
    );

endmodule

//--- logic/pwm_dac.sv
module pwm_dac import microstepper_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic [MAG_W-1:0] mag,
    output logic             pwm
);

    // free-running, one period is 256 cycles
    logic [MAG_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + MAG_W'(1);
        end
    end

    // high for exactly mag cycles per period, the RC filter does the rest
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (cnt < mag);
        end
    end

endmodule

//--- logic/step_input.sv
module step_input import microstepper_pkg::*; (
    input  logic   clk,
    input  logic   resetn,
    input  logic   step,
    input  logic   dir,
    output phase_t phase
);

    // two-flop synchronizers plus one extra stage on step for the edge
    logic step_s1;
    logic step_s2;
    logic step_s3;
    logic dir_s1;
    logic dir_s2;

    // registered edge and the direction that goes with it
    logic step_pulse;
    logic step_fwd;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_s1 <= 1'b0;
            step_s2 <= 1'b0;
            step_s3 <= 1'b0;
            dir_s1  <= 1'b0;
            dir_s2  <= 1'b0;
        end else begin
            step_s1 <= step;
            step_s2 <= step_s1;
            step_s3 <= step_s2;
            dir_s1  <= dir;
            dir_s2  <= dir_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_pulse <= 1'b0;
            step_fwd   <= 1'b0;
        end else begin
            step_pulse <= step_s2 & ~step_s3;
            step_fwd   <= dir_s2;
        end
    end

    // wraps modulo 256 in both directions
    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase.raw <= '0;
        end else if (step_pulse) begin
            phase.raw <= step_fwd ? phase.raw + PHASE_W'(1) : phase.raw - PHASE_W'(1);
        end
    end

endmodule

//--- project.f
logic/microstepper_pkg.sv
logic/step_input.sv
logic/current_table.sv
logic/pwm_dac.sv
logic/coil_chopper.sv
logic/bridge_driver.sv
logic/microstepper_top.sv
tb/tb_clock.sv
tb/microstepper_assert.sv
tb/microstepper_tb.sv

//--- tb/microstepper_assert.sv
module microstepper_assert import microstepper_pkg::*; (
    input logic               clk,
    input logic               resetn,
    input logic               enable_in,
    input logic [3:0]         inv_mask,
    input logic [3:0]         gates_a,
    input logic [3:0]         gates_b,
    input logic [PHASE_W-1:0] phase_raw
);

    // gate order per coil is {1_h, 1_l, 2_h, 2_l}
    function automatic logic no_shoot_through(input logic [3:0] g);
        return !(g[3] && g[2]) && !(g[1] && g[0]);
    endfunction

    // registered gates with the previous cycle's inversion undone
    leg_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        no_shoot_through(gates_a ^ $past(inv_mask)) &&
        no_shoot_through(gates_b ^ $past(inv_mask)))
        else $error("bridge leg with high and low gate on together");

    disabled_off: assert property (@(posedge clk) disable iff (!resetn)
        $past(!enable_in) |-> ((gates_a ^ $past(inv_mask)) == 4'h0) &&
                              ((gates_b ^ $past(inv_mask)) == 4'h0))
        else $error("bridge gates on while disabled");

    phase_step: assert property (@(posedge clk) disable iff (!resetn)
        (phase_raw == $past(phase_raw)) ||
        (phase_raw == $past(phase_raw) + PHASE_W'(1)) ||
        (phase_raw == $past(phase_raw) - PHASE_W'(1)))
        else $error("phase moved by more than one microstep");

endmodule

bind bridge_driver microstepper_assert bridge_checks (
    .clk(clk), .resetn(resetn), .enable_in(enable_in), .inv_mask(inv_mask),
    .gates_a(gates_a), .gates_b(gates_b), .phase_raw(8'h00)
);

bind step_input microstepper_assert step_checks (
    .clk(clk), .resetn(resetn), .enable_in(1'b1), .inv_mask(4'h0),
    .gates_a(4'h0), .gates_b(4'h0), .phase_raw(phase.raw)
);

//--- tb/microstepper_tb.sv
module microstepper_tb import microstepper_pkg::*; ();

    logic clk, resetn, step, dir, enable_in, analog_cmp_a, analog_cmp_b;
    logic [OFFTIME_W-1:0] config_offtime;
    logic [BLANK_W-1:0]   config_blanktime;
    logic [CP_W-1:0]      config_chargepump_period;
    logic inv_h, inv_l;
    logic phase_a1_h, phase_a1_l, phase_a2_h, phase_a2_l;
    logic phase_b1_h, phase_b1_l, phase_b2_h, phase_b2_l;
    logic analog_out_a, analog_out_b, chargepump_pin;
    logic [PHASE_W-1:0] position;
    logic [7:0] gates;
    phase_t model_phase;

    assign gates = {phase_a1_h, phase_a1_l, phase_a2_h, phase_a2_l,
                    phase_b1_h, phase_b1_l, phase_b2_h, phase_b2_l};

    tb_clock tb_clock_i (.clk(clk));

    microstepper_top microstepper_top_i (
        .clk(clk), .resetn(resetn), .step(step), .dir(dir), .enable_in(enable_in),
        .analog_cmp_a(analog_cmp_a), .analog_cmp_b(analog_cmp_b),
        .config_offtime(config_offtime), .config_blanktime(config_blanktime),
        .config_chargepump_period(config_chargepump_period),
        .config_invert_highside(inv_h), .config_invert_lowside(inv_l),
        .phase_a1_h(phase_a1_h), .phase_a1_l(phase_a1_l),
        .phase_a2_h(phase_a2_h), .phase_a2_l(phase_a2_l),
        .phase_b1_h(phase_b1_h), .phase_b1_l(phase_b1_l),
        .phase_b2_h(phase_b2_h), .phase_b2_l(phase_b2_l),
        .analog_out_a(analog_out_a), .analog_out_b(analog_out_b),
        .chargepump_pin(chargepump_pin), .position(position)
    );

    // ##############################
    // reference model
    // ##############################

    // sine for coil A, cosine for coil B, quarter wave mirrored in odd quadrants
    function automatic logic [MAG_W-1:0] fold_sine(input phase_t p, input logic cosine);
        logic mirror;
        logic [INDEX_W-1:0] i;
        case (p.split.quadrant)
            2'd0, 2'd2: mirror = cosine;
            default:    mirror = !cosine;
        endcase
        i = mirror ? INDEX_W'(TABLE_DEPTH - 1 - p.split.index) : p.split.index;
        return SINE_TABLE[i];
    endfunction

    function automatic logic [3:0] coil_gates(input logic en, input logic drive, input logic neg);
        logic hi1, lo1, hi2, lo2;
        hi1 = en && drive && !neg;
        hi2 = en && drive && neg;
        lo1 = hi2 || (en && !drive);
        lo2 = hi1 || (en && !drive);
        return {hi1 ^ inv_h, lo1 ^ inv_l, hi2 ^ inv_h, lo2 ^ inv_l};
    endfunction

    function automatic logic [7:0] expected_gates(input phase_t p);
        logic neg_a, neg_b;
        neg_a = (p.split.quadrant >= 2'd2);
        neg_b = (p.split.quadrant == 2'd1) || (p.split.quadrant == 2'd2);
        return {coil_gates(enable_in, 1'b1, neg_a), coil_gates(enable_in, 1'b1, neg_b)};
    endfunction

    // ##############################
    // checks
    // ##############################

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_phase(input string name, input phase_t got, input phase_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch %s: got %h, expected %h", name, got.raw, exp.raw));
    endtask

    task automatic check_mag(input string name, input logic [MAG_W-1:0] got,
                             input logic [MAG_W-1:0] exp);
        if (got !== exp)
            report_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_gates(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            report_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_period(input string name, input logic [CP_W-1:0] got,
                                input logic [CP_W-1:0] exp);
        if (got !== exp)
            report_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    // ##############################
    // stimulus
    // ##############################

    // position moves 3 cycles after the first edge that samples step high
    task automatic send_step(input logic fwd);
        int hi, lo, c;
        hi = 3 + $urandom_range(3);
        lo = 3 + $urandom_range(3);
        step = 1'b1;
        dir  = fwd;
        model_phase.raw = fwd ? model_phase.raw + 8'd1 : model_phase.raw - 8'd1;
        for (c = 0; c < hi + lo; c++) begin
            @(negedge clk);
            if (c == 3) check_phase("position", position, model_phase);
            if (c == hi - 1) step = 1'b0;
        end
    endtask

    // cycles until chargepump_pin next toggles
    task automatic time_toggle(output int n);
        logic last;
        last = chargepump_pin;
        n = 0;
        while (chargepump_pin == last) begin
            if (n == 300) report_error("charge pump stopped toggling");
            n++;
            @(negedge clk);
        end
    endtask

    initial begin
        int n, cnt_a, cnt_b, wait_cnt, off_len, interval;
        logic fwd;
        logic [3:0] decay_pat;
        void'($urandom(32'h852c));
        step = 1'b0;
        dir = 1'b0;
        enable_in = 1'b1;
        analog_cmp_a = 1'b0;
        analog_cmp_b = 1'b0;
        config_offtime = 10'd50;
        config_blanktime = 8'd10;
        config_chargepump_period = 8'd5;
        inv_h = 1'b0;
        inv_l = 1'b0;
        resetn = 1'b0;
        model_phase.raw = '0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_phase("position", position, model_phase);

        // steps, coil references, gating with random invert and enable
        for (int burst = 0; burst < 16; burst++) begin
            inv_h = $urandom_range(1);
            inv_l = $urandom_range(1);
            enable_in = ($urandom_range(3) != 0);
            fwd = $urandom_range(1);
            n = 1 + $urandom_range(30);
            for (int k = 0; k < n; k++) send_step(fwd);
            // the PWM output repeats every 256 cycles, so one window is one period
            cnt_a = 0;
            cnt_b = 0;
            for (int c = 0; c < 256; c++) begin
                @(negedge clk);
                cnt_a += analog_out_a;
                cnt_b += analog_out_b;
            end
            check_mag("analog_out_a", MAG_W'(cnt_a), fold_sine(model_phase, 1'b0));
            check_mag("analog_out_b", MAG_W'(cnt_b), fold_sine(model_phase, 1'b1));
            check_gates("gates", gates, expected_gates(model_phase));
        end

        // chopping on coil A
        enable_in = 1'b1;
        for (int t = 0; t < 4; t++) begin
            config_offtime = 20 + $urandom_range(60);
            config_blanktime = 4 + $urandom_range(12);
            repeat (40) @(negedge clk);
            decay_pat = coil_gates(1'b1, 1'b0, 1'b0);
            analog_cmp_a = 1'b1;
            wait_cnt = 0;
            while (gates[7:4] != decay_pat) begin
                if (wait_cnt == 40) report_error("coil A never entered slow decay");
                wait_cnt++;
                @(negedge clk);
            end
            analog_cmp_a = 1'b0;
            off_len = 0;
            while (gates[7:4] == decay_pat) begin
                if (off_len > 1100) report_error("coil A stuck in slow decay");
                off_len++;
                @(negedge clk);
            end
            if (off_len > config_offtime + 2 || off_len + 2 < config_offtime)
                report_error($sformatf("Mismatch off_time: got %h, expected %h",
                                       off_len, config_offtime));
            check_gates("gates", gates, expected_gates(model_phase));
        end

        // charge pump, the first interval after a change is partial
        for (int t = 0; t < 6; t++) begin
            config_chargepump_period = 1 + $urandom_range(39);
            time_toggle(interval);
            time_toggle(interval);
            check_period("chargepump_pin", CP_W'(interval), config_chargepump_period);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk
);

    // 8 time units per period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule
